// ==== list.f ====
+incdir+sim
rtl/valu_pkg.sv
rtl/valu_issue.sv
rtl/valu_lane_adder.sv
rtl/valu_shifter.sv
rtl/valu_multiplier.sv
rtl/valu_result_stage.sv
rtl/valu_top.sv
sim/valu_tb.sv

// ==== rtl/valu_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_issue
	import valu_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire [OPC_W-1:0] op_class,
	input wire [FN_W-1:0] funct,
	input wire [WW_W-1:0] width,
	input wire vec_word_u src_a,
	input wire vec_word_u src_b,
	input wire s1_ready,
	output logic in_ready,
	output logic s1_valid,
	output logic [FN_W-1:0] s1_funct,
	output logic [WW_W-1:0] s1_width,
	output vec_word_u s1_a,
	output vec_word_u s1_b,
	output logic s1_illegal
);

	logic take;
	logic legal_class;
	logic is_mul;
	logic illegal_next;

	// Empty register or downstream draining this cycle
	assign in_ready = !s1_valid || s1_ready;
	assign take = in_valid && in_ready;

	always_comb begin
		case (op_class)
			OPC_R_ALU: legal_class = 1'b1;
			// Memory, branch and nop classes go to other units
			OPC_LOAD, OPC_STORE, OPC_BRANCH_EZ, OPC_BRANCH_NZ, OPC_NOP: legal_class = 1'b0;
			default: legal_class = 1'b0;
		endcase
	end

	assign is_mul = (funct == FN_MULEU) || (funct == FN_MULOU);

	// No 128-bit products, so 64-bit lane multiply is rejected
	assign illegal_next = !legal_class || (funct > FN_RTTH) || (is_mul && width == WIDTH_64);

	// Stage valid
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else if (in_ready) begin
			s1_valid <= in_valid;
		end
	end

	// Operands and decoded fields
	always_ff @(posedge clk) begin
		if (take) begin
			s1_funct <= funct;
			s1_width <= width;
			s1_a <= src_a;
			s1_b <= src_b;
			s1_illegal <= illegal_next;
		end
	end

	// Offered instruction stays put until taken
	a_in_hold: assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid && $stable(funct) && $stable(op_class)
			&& $stable(width) && $stable(src_a) && $stable(src_b))
		else $error("input channel dropped or changed before acceptance");

	// Stalled stage 1 keeps its contents
	a_s1_hold: assert property (@(posedge clk) disable iff (rst)
		s1_valid && !s1_ready |=> s1_valid && $stable(s1_funct) && $stable(s1_width)
			&& $stable(s1_a) && $stable(s1_b) && $stable(s1_illegal))
		else $error("stage 1 changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/valu_lane_adder.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_lane_adder
	import valu_pkg::*;
(
	input wire [FN_W-1:0] s1_funct,
	input wire [WW_W-1:0] s1_width,
	input wire vec_word_u s1_a,
	input wire vec_word_u s1_b,
	output vec_word_u sum
);

	logic sub;
	vec_word_u b_op;
	logic [2:0] lane_mask;
	logic [2:0] pos;
	logic carry;
	logic cin;

	assign sub = (s1_funct == FN_SUB);

	// Subtract as A plus inverted B plus one
	assign b_op.d64 = sub ? ~s1_b.d64 : s1_b.d64;

	// Bytes per lane minus one
	// 000, 001, 011, 111 for 8 to 64 bits
	assign lane_mask = 3'b111 >> (2'd3 - s1_width);

	// Byte-wide ripple, lowest byte first
	always_comb begin
		carry = 1'b0;
		cin = 1'b0;
		pos = 3'd0;
		sum.d64 = '0;
		for (int k = LANES_8 - 1; k >= 0; k--) begin
			pos = 3'(k);
			// Lowest byte of a lane restarts the chain
			if ((pos & lane_mask) == lane_mask) begin
				cin = sub;
			end else begin
				cin = carry;
			end
			// Carry out of the lane top is simply dropped
			{carry, sum.b8[k]} = s1_a.b8[k] + b_op.b8[k] + cin;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/valu_multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_multiplier
	import valu_pkg::*;
(
	input wire [FN_W-1:0] s1_funct,
	input wire [WW_W-1:0] s1_width,
	input wire vec_word_u s1_a,
	input wire vec_word_u s1_b,
	output vec_word_u product
);

	logic odd;
	logic mul_en;

	// Odd picks lanes 1, 3, 5..., even picks 0, 2, 4...
	assign odd = (s1_funct == FN_MULOU);
	assign mul_en = odd || (s1_funct == FN_MULEU);

	// Source lane 2k+odd feeds double-width lane k
	always_comb begin
		product.d64 = '0;
		if (mul_en) begin
			case (s1_width)
				WIDTH_8: begin
					for (int k = 0; k < LANES_8 / 2; k++) begin
						product.h16[k] = s1_a.b8[2 * k + odd] * s1_b.b8[2 * k + odd];
					end
				end
				WIDTH_16: begin
					for (int k = 0; k < LANES_16 / 2; k++) begin
						product.w32[k] = s1_a.h16[2 * k + odd] * s1_b.h16[2 * k + odd];
					end
				end
				WIDTH_32: begin
					// Single 64-bit product
					product.d64 = s1_a.w32[odd] * s1_b.w32[odd];
				end
				default: begin
					// 64-bit lanes flagged illegal at issue
					product.d64 = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/valu_pkg.sv ====
`default_nettype none

package valu_pkg;

	// Datapath word
	localparam int DATA_W = 64;

	// Lane counts per width
	localparam int LANES_8 = 8;
	localparam int LANES_16 = 4;
	localparam int LANES_32 = 2;

	// Field widths of the instruction
	localparam int OPC_W = 6;
	localparam int FN_W = 6;
	localparam int WW_W = 2;

	// Lane width codes
	localparam logic [WW_W-1:0] WIDTH_8 = 2'b00;
	localparam logic [WW_W-1:0] WIDTH_16 = 2'b01;
	localparam logic [WW_W-1:0] WIDTH_32 = 2'b10;
	localparam logic [WW_W-1:0] WIDTH_64 = 2'b11;

	// Instruction classes
	// Only the register ALU class runs here
	localparam logic [OPC_W-1:0] OPC_R_ALU = 6'b101010;
	localparam logic [OPC_W-1:0] OPC_LOAD = 6'b100000;
	localparam logic [OPC_W-1:0] OPC_STORE = 6'b100001;
	localparam logic [OPC_W-1:0] OPC_BRANCH_EZ = 6'b100010;
	localparam logic [OPC_W-1:0] OPC_BRANCH_NZ = 6'b100011;
	localparam logic [OPC_W-1:0] OPC_NOP = 6'b111100;

	// Function codes
	localparam logic [FN_W-1:0] FN_NOP = 6'd0;
	localparam logic [FN_W-1:0] FN_AND = 6'd1;
	localparam logic [FN_W-1:0] FN_OR = 6'd2;
	localparam logic [FN_W-1:0] FN_XOR = 6'd3;
	localparam logic [FN_W-1:0] FN_NOT = 6'd4;
	localparam logic [FN_W-1:0] FN_MOV = 6'd5;
	localparam logic [FN_W-1:0] FN_ADD = 6'd6;
	localparam logic [FN_W-1:0] FN_SUB = 6'd7;
	// Widening multiplies
	localparam logic [FN_W-1:0] FN_MULEU = 6'd8;
	localparam logic [FN_W-1:0] FN_MULOU = 6'd9;
	// Shifts and half swap
	localparam logic [FN_W-1:0] FN_SLL = 6'd10;
	localparam logic [FN_W-1:0] FN_SRL = 6'd11;
	localparam logic [FN_W-1:0] FN_SRA = 6'd12;
	// Last supported code, everything above is rejected
	localparam logic [FN_W-1:0] FN_RTTH = 6'd13;

	// One 64-bit operand seen at every lane width
	// Element 0 is the most significant lane
	typedef union packed {
		logic [0:LANES_8-1][7:0] b8;
		logic [0:LANES_16-1][15:0] h16;
		logic [0:LANES_32-1][31:0] w32;
		logic [DATA_W-1:0] d64;
	} vec_word_u;

endpackage

`default_nettype wire

// ==== rtl/valu_result_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_result_stage
	import valu_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire s1_valid,
	input wire [FN_W-1:0] s1_funct,
	input wire s1_illegal,
	input wire vec_word_u s1_a,
	input wire vec_word_u s1_b,
	input wire vec_word_u sum,
	input wire vec_word_u shift_out,
	input wire vec_word_u product,
	input wire out_ready,
	output logic s1_ready,
	output logic out_valid,
	output vec_word_u result,
	output logic illegal
);

	vec_word_u res_next;

	// Output register empty or being read now
	assign s1_ready = !out_valid || out_ready;

	// Bitwise ops locally, the rest from the units
	always_comb begin
		case (s1_funct)
			FN_NOP: res_next.d64 = '0;
			FN_AND: res_next.d64 = s1_a.d64 & s1_b.d64;
			FN_OR: res_next.d64 = s1_a.d64 | s1_b.d64;
			FN_XOR: res_next.d64 = s1_a.d64 ^ s1_b.d64;
			FN_NOT: res_next.d64 = ~s1_a.d64;
			FN_MOV: res_next.d64 = s1_a.d64;
			FN_ADD, FN_SUB: res_next = sum;
			FN_MULEU, FN_MULOU: res_next = product;
			FN_SLL, FN_SRL, FN_SRA, FN_RTTH: res_next = shift_out;
			default: res_next.d64 = '0;
		endcase
		// Rejected instructions return zero
		if (s1_illegal) begin
			res_next.d64 = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (s1_ready) begin
			out_valid <= s1_valid;
		end
	end

	// Loaded only on a stage 1 transfer
	always_ff @(posedge clk) begin
		if (s1_valid && s1_ready) begin
			result <= res_next;
			illegal <= s1_illegal;
		end
	end

	// Held output while the sink stalls
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(illegal))
		else $error("output changed under back-pressure");

	// Nothing left over from before reset
	a_rst_empty: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after reset");

endmodule

`default_nettype wire

// ==== rtl/valu_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_shifter
	import valu_pkg::*;
(
	input wire [FN_W-1:0] s1_funct,
	input wire [WW_W-1:0] s1_width,
	input wire vec_word_u s1_a,
	input wire vec_word_u s1_b,
	output vec_word_u shift_out
);

	logic [DATA_W-1:0] tmp;

	// One lane of lw bits, zero extended in a 64-bit container
	function automatic logic [DATA_W-1:0] lane_op(
		input logic [DATA_W-1:0] a,
		input logic [5:0] amt,
		input int lw,
		input logic [FN_W-1:0] fn
	);
		logic [DATA_W-1:0] mask;
		logic [DATA_W-1:0] aj;
		logic [DATA_W-1:0] r;
		mask = {DATA_W{1'b1}} >> (DATA_W - lw);
		// Left justified copy, lane sign lands on bit 63
		aj = a << (DATA_W - lw);
		case (fn)
			FN_SLL: r = (a << amt) & mask;
			FN_SRL: r = a >> amt;
			FN_SRA: begin
				r = $signed(aj) >>> amt;
				r = r >> (DATA_W - lw);
			end
			// Upper and lower halves trade places
			FN_RTTH: r = ((a << (lw / 2)) | (a >> (lw / 2))) & mask;
			default: r = '0;
		endcase
		return r;
	endfunction

	// Amount is the low log2(width) bits of the matching B lane
	always_comb begin
		tmp = '0;
		shift_out.d64 = '0;
		case (s1_width)
			WIDTH_8: begin
				for (int i = 0; i < LANES_8; i++) begin
					tmp = lane_op(s1_a.b8[i], s1_b.b8[i][2:0], DATA_W / LANES_8, s1_funct);
					shift_out.b8[i] = tmp[7:0];
				end
			end
			WIDTH_16: begin
				for (int i = 0; i < LANES_16; i++) begin
					tmp = lane_op(s1_a.h16[i], s1_b.h16[i][3:0], DATA_W / LANES_16, s1_funct);
					shift_out.h16[i] = tmp[15:0];
				end
			end
			WIDTH_32: begin
				for (int i = 0; i < LANES_32; i++) begin
					tmp = lane_op(s1_a.w32[i], s1_b.w32[i][4:0], DATA_W / LANES_32, s1_funct);
					shift_out.w32[i] = tmp[31:0];
				end
			end
			WIDTH_64: begin
				// Whole word as a single lane
				tmp = lane_op(s1_a.d64, s1_b.d64[5:0], DATA_W, s1_funct);
				shift_out.d64 = tmp;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/valu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_top
	import valu_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire [OPC_W-1:0] op_class,
	input wire [FN_W-1:0] funct,
	input wire [WW_W-1:0] width,
	input wire vec_word_u src_a,
	input wire vec_word_u src_b,
	input wire out_ready,
	output logic in_ready,
	output logic out_valid,
	output vec_word_u result,
	output logic illegal
);

	// Stage 1 register outputs
	logic s1_valid;
	logic s1_ready;
	logic [FN_W-1:0] s1_funct;
	logic [WW_W-1:0] s1_width;
	vec_word_u s1_a;
	vec_word_u s1_b;
	logic s1_illegal;

	// Unit results
	vec_word_u sum;
	vec_word_u shift_out;
	vec_word_u product;

	valu_issue u_issue (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.op_class(op_class),
		.funct(funct),
		.width(width),
		.src_a(src_a),
		.src_b(src_b),
		.s1_ready(s1_ready),
		.in_ready(in_ready),
		.s1_valid(s1_valid),
		.s1_funct(s1_funct),
		.s1_width(s1_width),
		.s1_a(s1_a),
		.s1_b(s1_b),
		.s1_illegal(s1_illegal)
	);

	valu_lane_adder u_adder (
		.s1_funct(s1_funct),
		.s1_width(s1_width),
		.s1_a(s1_a),
		.s1_b(s1_b),
		.sum(sum)
	);

	valu_shifter u_shifter (
		.s1_funct(s1_funct),
		.s1_width(s1_width),
		.s1_a(s1_a),
		.s1_b(s1_b),
		.shift_out(shift_out)
	);

	valu_multiplier u_multiplier (
		.s1_funct(s1_funct),
		.s1_width(s1_width),
		.s1_a(s1_a),
		.s1_b(s1_b),
		.product(product)
	);

	valu_result_stage u_result (
		.clk(clk),
		.rst(rst),
		.s1_valid(s1_valid),
		.s1_funct(s1_funct),
		.s1_illegal(s1_illegal),
		.s1_a(s1_a),
		.s1_b(s1_b),
		.sum(sum),
		.shift_out(shift_out),
		.product(product),
		.out_ready(out_ready),
		.s1_ready(s1_ready),
		.out_valid(out_valid),
		.result(result),
		.illegal(illegal)
	);

endmodule

`default_nettype wire

// ==== sim/valu_tests.svh ====
`ifndef VALU_TESTS_SVH
`define VALU_TESTS_SVH

// Empty after reset, then one ADD through both stages
task automatic latency_check();
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	a = rand_word();
	b = rand_word();
	@(negedge clk);
	expect_eq("out_valid", 1'b0, out_valid);
	expect_eq("in_ready", 1'b1, in_ready);
	@(posedge clk);
	#1;
	op_class = OPC_R_ALU;
	funct = FN_ADD;
	width = WIDTH_16;
	src_a.d64 = a;
	src_b.d64 = b;
	in_valid = 1'b1;
	// Edge N takes it
	@(posedge clk);
	#1;
	in_valid = 1'b0;
	@(negedge clk);
	expect_eq("out_valid", 1'b0, out_valid);
	// Visible after edge N+1
	@(negedge clk);
	expect_eq("out_valid", 1'b1, out_valid);
	expect_eq("result", model_result(OPC_R_ALU, FN_ADD, WIDTH_16, a, b), result.d64);
	expect_eq("illegal", 1'b0, illegal);
	@(posedge clk);
	#1;
endtask

task automatic add_sub_lanes();
	logic [DATA_W-1:0] a_fix[3];
	logic [DATA_W-1:0] b_fix[3];
	// Carry out and borrow at every lane top
	a_fix = '{64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_7FFF_8000_7FFF, 64'h0};
	b_fix = '{64'h0101_0101_0101_0101, 64'h8000_0001_8000_0001, 64'h0000_0001_0000_0001};
	for (int w = 0; w < 4; w++) begin
		for (int f = FN_ADD; f <= FN_SUB; f++) begin
			for (int i = 0; i < 3; i++) begin
				run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), a_fix[i], b_fix[i]);
			end
			repeat (6) begin
				run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), rand_word(), rand_word());
			end
		end
	end
endtask

// NOP through MOV, width ignored
task automatic logic_ops();
	for (int f = FN_NOP; f <= FN_MOV; f++) begin
		repeat (4) begin
			run_one(OPC_R_ALU, FN_W'(f), WW_W'($random(seed)), rand_word(), rand_word());
		end
	end
endtask

task automatic shift_ops();
	for (int w = 0; w < 4; w++) begin
		for (int f = FN_SLL; f <= FN_RTTH; f++) begin
			// Every lane negative at every width
			run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), 64'hF0E1_D2C3_B4A5_9687,
				64'h0713_2F05_3F0B_1E39);
			repeat (5) begin
				run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), rand_word(), rand_word());
			end
		end
	end
endtask

task automatic widening_mul();
	for (int w = 0; w < 3; w++) begin
		for (int f = FN_MULEU; f <= FN_MULOU; f++) begin
			// Largest product per lane
			run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), '1, '1);
			repeat (4) begin
				run_one(OPC_R_ALU, FN_W'(f), WW_W'(w), rand_word(), rand_word());
			end
		end
	end
	// Rejected: 64-bit multiply, dropped codes, load class
	run_one(OPC_R_ALU, FN_MULEU, WIDTH_64, rand_word(), rand_word());
	run_one(OPC_R_ALU, FN_MULOU, WIDTH_64, rand_word(), rand_word());
	run_one(OPC_R_ALU, 6'd14, WIDTH_32, rand_word(), rand_word());
	run_one(OPC_R_ALU, 6'd18, WIDTH_8, rand_word(), rand_word());
	run_one(OPC_LOAD, FN_ADD, WIDTH_16, rand_word(), rand_word());
endtask

// Two accepted, third stalls until the sink drains
task automatic back_pressure();
	out_ready = 1'b0;
	send_instr(OPC_R_ALU, FN_ADD, WIDTH_8, rand_word(), rand_word());
	send_instr(OPC_R_ALU, FN_SRA, WIDTH_16, rand_word(), rand_word());
	fork
		send_instr(OPC_R_ALU, FN_MULOU, WIDTH_32, rand_word(), rand_word());
		begin
			@(negedge clk);
			// Oldest result parked at the output
			repeat (3) begin
				expect_eq("in_ready", 1'b0, in_ready);
				expect_eq("out_valid", 1'b1, out_valid);
				expect_eq("result", exp_q[0], result.d64);
				expect_eq("illegal", exp_ill_q[0], illegal);
				@(negedge clk);
			end
			@(posedge clk);
			#1;
			out_ready = 1'b1;
			// Oldest first
			repeat (3) begin
				collect_result();
			end
			// No extra copy behind the last one
			@(negedge clk);
			expect_eq("out_valid", 1'b0, out_valid);
		end
	join
endtask

`endif

// ==== sim/valu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module valu_tb
	import valu_pkg::*;
();

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic [OPC_W-1:0] op_class;
	logic [FN_W-1:0] funct;
	logic [WW_W-1:0] width;
	vec_word_u src_a;
	vec_word_u src_b;
	logic out_valid;
	logic out_ready;
	vec_word_u result;
	logic illegal;

	integer seed;
	int max_wait;
	// Expected outputs in issue order
	logic [DATA_W-1:0] exp_q[$];
	logic exp_ill_q[$];

	valu_top u_valu_top (.*);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Wrong class, codes past RTTH, or multiply on a 64-bit lane
	function automatic logic model_illegal(
		input logic [OPC_W-1:0] op,
		input logic [FN_W-1:0] fn,
		input logic [WW_W-1:0] w
	);
		logic mul;
		mul = (fn == FN_MULEU) || (fn == FN_MULOU);
		return (op != OPC_R_ALU) || (fn > FN_RTTH) || (mul && w == WIDTH_64);
	endfunction

	// Lane rules, lane 0 in the top bits
	function automatic logic [DATA_W-1:0] model_result(
		input logic [OPC_W-1:0] op,
		input logic [FN_W-1:0] fn,
		input logic [WW_W-1:0] w,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		int lw;
		int n;
		int sh;
		int amt;
		int src;
		logic [DATA_W-1:0] m;
		logic [DATA_W-1:0] la;
		logic [DATA_W-1:0] lb;
		logic [DATA_W-1:0] lane;
		logic [DATA_W-1:0] r;
		lw = 8 << w;
		n = DATA_W / lw;
		m = ~64'd0 >> (DATA_W - lw);
		r = '0;
		if (model_illegal(op, fn, w)) begin
			return '0;
		end
		case (fn)
			FN_AND: r = a & b;
			FN_OR: r = a | b;
			FN_XOR: r = a ^ b;
			FN_NOT: r = ~a;
			FN_MOV: r = a;
			FN_MULEU, FN_MULOU: begin
				// Source lane 2k or 2k+1 widens into double lane k
				for (int k = 0; k < n / 2; k++) begin
					src = 2 * k + (fn == FN_MULOU);
					sh = (n - 1 - src) * lw;
					la = (a >> sh) & m;
					lb = (b >> sh) & m;
					r = r | ((la * lb) << ((n / 2 - 1 - k) * 2 * lw));
				end
			end
			FN_ADD, FN_SUB, FN_SLL, FN_SRL, FN_SRA, FN_RTTH: begin
				for (int i = 0; i < n; i++) begin
					sh = (n - 1 - i) * lw;
					la = (a >> sh) & m;
					lb = (b >> sh) & m;
					// Amount from the low log2(lw) bits of the B lane
					amt = int'(lb[5:0]) & (lw - 1);
					case (fn)
						FN_ADD: lane = la + lb;
						FN_SUB: lane = la - lb;
						FN_SLL: lane = la << amt;
						FN_SRL: lane = la >> amt;
						FN_SRA: begin
							lane = la >> amt;
							// Sign fill of the vacated top bits
							if (la[lw - 1]) begin
								lane = lane | (m & ~(m >> amt));
							end
						end
						FN_RTTH: lane = (la << (lw / 2)) | (la >> (lw / 2));
						default: lane = '0;
					endcase
					// Masking drops carries out of the lane
					r = r | ((lane & m) << sh);
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [DATA_W-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic expect_eq(
		input string name,
		input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] got
	);
		assert (got === exp) else begin
			abort_run($sformatf("[ERROR] %t %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	// Offer one instruction and hold it until the transfer edge
	task automatic send_instr(
		input logic [OPC_W-1:0] op,
		input logic [FN_W-1:0] fn,
		input logic [WW_W-1:0] w,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		int waited;
		logic taken;
		waited = 0;
		exp_q.push_back(model_result(op, fn, w, a, b));
		exp_ill_q.push_back(model_illegal(op, fn, w));
		op_class = op;
		funct = fn;
		width = w;
		src_a.d64 = a;
		src_b.d64 = b;
		in_valid = 1'b1;
		// in_ready sampled mid-cycle
		@(negedge clk);
		taken = in_ready;
		while (!taken) begin
			waited++;
			if (waited > max_wait) begin
				abort_run("timeout: the input channel never accepted the instruction");
			end
			@(negedge clk);
			taken = in_ready;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// Wait for the next output transfer and compare it
	task automatic collect_result();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!(out_valid && out_ready)) begin
			waited++;
			if (waited > max_wait) begin
				abort_run("timeout: no result came out of the output channel");
			end
			@(negedge clk);
		end
		if (exp_q.size() == 0) begin
			abort_run("a result came out with no instruction outstanding");
		end
		expect_eq("result", exp_q.pop_front(), result.d64);
		expect_eq("illegal", exp_ill_q.pop_front(), illegal);
		@(posedge clk);
		#1;
	endtask

	task automatic run_one(
		input logic [OPC_W-1:0] op,
		input logic [FN_W-1:0] fn,
		input logic [WW_W-1:0] w,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		send_instr(op, fn, w, a, b);
		collect_result();
	endtask

	`include "valu_tests.svh"

	initial begin
		$timeformat(-9, 2, " ns", 0);
		seed = 32'hb15c9aba;
		max_wait = 40;
		rst = 1'b1;
		in_valid = 1'b0;
		op_class = OPC_NOP;
		funct = FN_NOP;
		width = WIDTH_8;
		src_a.d64 = '0;
		src_b.d64 = '0;
		out_ready = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		latency_check();
		add_sub_lanes();
		logic_ops();
		shift_ops();
		widening_mul();
		back_pressure();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
